// ==== mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

`define MEM_WORD_BITS   32
`define MEM_LINE_WORDS  4
`define MEM_LINE_BITS   128
`define MEM_OFFSET_BITS 4    // byte offset inside a line
`define MEM_INDEX_BITS  3
`define MEM_TAG_BITS    25

`define MEM_IC_LINES    8
`define MEM_DC_LINES    8

`endif

// ==== mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

    typedef logic [`MEM_WORD_BITS-1:0] word_t;

    // word 0 in the low bits
    typedef logic [`MEM_LINE_BITS-1:0] line_t;

    typedef logic [`MEM_TAG_BITS-1:0] tag_t;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_WRITE,
        BR_READ
    } bridge_state_t;

    // who owns the current burst
    typedef enum logic {
        REQ_FETCH,
        REQ_DATA
    } requester_t;

endpackage

// ==== line_mem_bridge.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module line_mem_bridge (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            ic_req_i,
    input  mem_pkg::word_t  ic_addr_i,

    input  logic            dc_req_i,
    input  logic            dc_we_i,
    input  mem_pkg::word_t  dc_addr_i,
    input  mem_pkg::line_t  dc_wline_i,

    input  logic            mem_ready_i,
    input  mem_pkg::word_t  mem_rdata_i,

    output logic            free_o,
    output mem_pkg::line_t  rline_o,
    output logic            ic_done_o,
    output logic            dc_done_o,

    output logic            mem_valid_o,
    output mem_pkg::word_t  mem_addr_o,
    output mem_pkg::word_t  mem_wdata_o,
    output logic [3:0]      mem_wstrb_o
);
    import mem_pkg::*;

    localparam logic [1:0] LAST_BEAT = 2'(`MEM_LINE_WORDS - 1);

    bridge_state_t state_r, state_nx;
    requester_t    who_r, who_nx;
    logic [1:0]    cnt_r, cnt_nx;     // beat within the line
    word_t         addr_r, addr_nx;
    word_t         wdata_r, wdata_nx;
    logic [3:0]    wstrb_r, wstrb_nx;
    logic          valid_r, valid_nx;
    line_t         line_r, line_nx;
    logic          ic_done_r, ic_done_nx;
    logic          dc_done_r, dc_done_nx;
    logic          take;

    // the requester still sees its request high during its done cycle
    assign take = (state_r == BR_IDLE) && !ic_done_r && !dc_done_r;

    always_comb begin
        state_nx   = state_r;
        who_nx     = who_r;
        cnt_nx     = cnt_r;
        addr_nx    = addr_r;
        wdata_nx   = wdata_r;
        wstrb_nx   = wstrb_r;
        valid_nx   = valid_r;
        line_nx    = line_r;
        ic_done_nx = 1'b0;
        dc_done_nx = 1'b0;

        case (state_r)
            BR_IDLE: begin
                valid_nx = 1'b0;
                if (take && dc_req_i) begin   // data side first
                    who_nx   = REQ_DATA;
                    addr_nx  = dc_addr_i;
                    cnt_nx   = 2'd0;
                    valid_nx = 1'b1;
                    if (dc_we_i) begin
                        wstrb_nx = 4'hF;
                        wdata_nx = dc_wline_i[`MEM_WORD_BITS-1:0];
                        state_nx = BR_WRITE;
                    end else begin
                        wstrb_nx = 4'h0;
                        state_nx = BR_READ;
                    end
                end else if (take && ic_req_i) begin
                    who_nx   = REQ_FETCH;
                    addr_nx  = ic_addr_i;
                    cnt_nx   = 2'd0;
                    valid_nx = 1'b1;
                    wstrb_nx = 4'h0;
                    state_nx = BR_READ;
                end
            end
            BR_WRITE: begin
                if (mem_ready_i) begin
                    if (cnt_r == LAST_BEAT) begin
                        valid_nx   = 1'b0;
                        ic_done_nx = (who_r == REQ_FETCH);
                        dc_done_nx = (who_r == REQ_DATA);
                        state_nx   = BR_IDLE;
                    end else begin
                        cnt_nx   = cnt_r + 2'd1;
                        addr_nx  = addr_r + 32'd4;
                        wdata_nx = word_t'(dc_wline_i >> {cnt_nx, 5'b0});
                    end
                end
            end
            BR_READ: begin
                if (mem_ready_i) begin
                    // shift in from the top, word 0 lands low
                    line_nx = {mem_rdata_i, line_r[`MEM_LINE_BITS-1:`MEM_WORD_BITS]};
                    if (cnt_r == LAST_BEAT) begin
                        valid_nx   = 1'b0;
                        ic_done_nx = (who_r == REQ_FETCH);
                        dc_done_nx = (who_r == REQ_DATA);
                        state_nx   = BR_IDLE;
                    end else begin
                        cnt_nx  = cnt_r + 2'd1;
                        addr_nx = addr_r + 32'd4;
                    end
                end
            end
            default: begin
                valid_nx = 1'b0;
                state_nx = BR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r   <= BR_IDLE;
            who_r     <= REQ_FETCH;
            cnt_r     <= 2'd0;
            wstrb_r   <= 4'h0;
            valid_r   <= 1'b0;
            ic_done_r <= 1'b0;
            dc_done_r <= 1'b0;
        end else begin
            state_r   <= state_nx;
            who_r     <= who_nx;
            cnt_r     <= cnt_nx;
            wstrb_r   <= wstrb_nx;
            valid_r   <= valid_nx;
            ic_done_r <= ic_done_nx;
            dc_done_r <= dc_done_nx;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_r  <= addr_nx;
        wdata_r <= wdata_nx;
        line_r  <= line_nx;
    end

    assign free_o      = (state_r == BR_IDLE);
    assign rline_o     = line_r;
    assign ic_done_o   = ic_done_r;
    assign dc_done_o   = dc_done_r;
    assign mem_valid_o = valid_r;
    assign mem_addr_o  = addr_r;
    assign mem_wdata_o = wdata_r;
    assign mem_wstrb_o = wstrb_r;

endmodule

// ==== icache_line.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module icache_line (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            fetch_req_i,
    input  mem_pkg::word_t  fetch_addr_i,
    output logic            fetch_valid_o,
    output mem_pkg::word_t  fetch_data_o,

    input  logic            free_i,
    input  mem_pkg::line_t  rline_i,
    input  logic            done_i,
    output logic            req_o,
    output mem_pkg::word_t  addr_o
);
    import mem_pkg::*;

    line_t                     line_q [`MEM_IC_LINES];
    tag_t                      tag_q  [`MEM_IC_LINES];
    logic [`MEM_IC_LINES-1:0]  valid_q;

    logic [`MEM_INDEX_BITS-1:0] idx;
    logic [1:0]                 woff;
    tag_t                       tag;
    logic                       hit;
    logic                       start;

    logic   req_r;
    logic   valid_r;
    word_t  addr_r;
    word_t  data_r;

    assign idx  = fetch_addr_i[`MEM_OFFSET_BITS +: `MEM_INDEX_BITS];
    assign woff = fetch_addr_i[3:2];
    assign tag  = fetch_addr_i[31 -: `MEM_TAG_BITS];
    assign hit  = valid_q[idx] && (tag_q[idx] == tag);

    // skip the cycle where the last answer is still out
    assign start = fetch_req_i && !valid_r && !req_r;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            req_r   <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            valid_r <= 1'b0;
            if (req_r) begin
                if (done_i) begin
                    req_r        <= 1'b0;
                    valid_r      <= 1'b1;
                    valid_q[idx] <= 1'b1;
                end
            end else if (start) begin
                if (hit)
                    valid_r <= 1'b1;
                else if (free_i)
                    req_r <= 1'b1;      // wait for an idle bridge
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_r && done_i) begin
            line_q[idx] <= rline_i;
            tag_q[idx]  <= tag;
            data_r      <= word_t'(rline_i >> {woff, 5'b0});
        end else if (start && hit) begin
            data_r <= word_t'(line_q[idx] >> {woff, 5'b0});
        end
        if (start && !hit)
            addr_r <= {fetch_addr_i[31:`MEM_OFFSET_BITS], {`MEM_OFFSET_BITS{1'b0}}};
    end

    assign fetch_valid_o = valid_r;
    assign fetch_data_o  = data_r;
    assign req_o         = req_r;
    assign addr_o        = addr_r;

endmodule

// ==== dcache_line.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module dcache_line (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            data_req_i,
    input  logic            data_we_i,
    input  mem_pkg::word_t  data_addr_i,
    input  mem_pkg::word_t  data_wdata_i,
    output logic            data_valid_o,
    output mem_pkg::word_t  data_rdata_o,

    input  logic            free_i,
    input  mem_pkg::line_t  rline_i,
    input  logic            done_i,
    output logic            req_o,
    output logic            we_o,
    output mem_pkg::word_t  addr_o,
    output mem_pkg::line_t  wline_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {DC_IDLE, DC_WB, DC_FILL} dc_state_t;

    line_t                     line_q [`MEM_DC_LINES];
    tag_t                      tag_q  [`MEM_DC_LINES];
    logic [`MEM_DC_LINES-1:0]  valid_q;
    logic [`MEM_DC_LINES-1:0]  dirty_q;

    logic [`MEM_INDEX_BITS-1:0] idx;
    logic [1:0]                 woff;
    tag_t                       tag;
    logic                       hit;
    logic                       start;
    logic                       fill_done;
    word_t                      line_addr;
    line_t                      src_line;
    line_t                      new_line;

    dc_state_t state_r;
    logic      req_r;
    logic      we_r;
    logic      valid_r;
    word_t     addr_r;
    line_t     wline_r;
    word_t     rdata_r;

    assign idx       = data_addr_i[`MEM_OFFSET_BITS +: `MEM_INDEX_BITS];
    assign woff      = data_addr_i[3:2];
    assign tag       = data_addr_i[31 -: `MEM_TAG_BITS];
    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign start     = data_req_i && !valid_r && (state_r == DC_IDLE);
    assign fill_done = (state_r == DC_FILL) && done_i;
    assign line_addr = {data_addr_i[31:`MEM_OFFSET_BITS], {`MEM_OFFSET_BITS{1'b0}}};

    // refill finishes the pending access in the same cycle
    assign src_line = (state_r == DC_FILL) ? rline_i : line_q[idx];

    always_comb begin
        new_line = src_line;
        if (data_we_i)
            new_line[{woff, 5'b0} +: `MEM_WORD_BITS] = data_wdata_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r <= DC_IDLE;
            req_r   <= 1'b0;
            we_r    <= 1'b0;
            valid_r <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            valid_r <= 1'b0;
            case (state_r)
                DC_IDLE: begin
                    if (start && hit) begin
                        valid_r <= 1'b1;
                        if (data_we_i)
                            dirty_q[idx] <= 1'b1;
                    end else if (start && free_i) begin
                        req_r <= 1'b1;
                        if (valid_q[idx] && dirty_q[idx]) begin
                            we_r    <= 1'b1;     // victim goes out first
                            state_r <= DC_WB;
                        end else begin
                            we_r    <= 1'b0;
                            state_r <= DC_FILL;
                        end
                    end
                end
                DC_WB: begin
                    if (done_i) begin
                        we_r    <= 1'b0;         // req stays up for the refill
                        state_r <= DC_FILL;
                    end
                end
                DC_FILL: begin
                    if (done_i) begin
                        req_r        <= 1'b0;
                        valid_r      <= 1'b1;
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= data_we_i;
                        state_r      <= DC_IDLE;
                    end
                end
                default: state_r <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((start && hit && data_we_i) || fill_done)
            line_q[idx] <= new_line;
        if (fill_done)
            tag_q[idx] <= tag;
        if ((start && hit) || fill_done)
            rdata_r <= word_t'(src_line >> {woff, 5'b0});
        if (start && !hit) begin
            wline_r <= line_q[idx];
            if (valid_q[idx] && dirty_q[idx])
                addr_r <= {tag_q[idx], idx, {`MEM_OFFSET_BITS{1'b0}}};
            else
                addr_r <= line_addr;
        end else if ((state_r == DC_WB) && done_i) begin
            addr_r <= line_addr;
        end
    end

    assign data_valid_o = valid_r;
    assign data_rdata_o = rdata_r;
    assign req_o        = req_r;
    assign we_o         = we_r;
    assign addr_o       = addr_r;
    assign wline_o      = wline_r;

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            fetch_req_i,
    input  mem_pkg::word_t  fetch_addr_i,
    output logic            fetch_valid_o,
    output mem_pkg::word_t  fetch_data_o,

    input  logic            data_req_i,
    input  logic            data_we_i,
    input  mem_pkg::word_t  data_addr_i,
    input  mem_pkg::word_t  data_wdata_i,
    output logic            data_valid_o,
    output mem_pkg::word_t  data_rdata_o,

    output logic            mem_valid_o,
    output mem_pkg::word_t  mem_addr_o,
    output mem_pkg::word_t  mem_wdata_o,
    output logic [3:0]      mem_wstrb_o,
    input  logic            mem_ready_i,
    input  mem_pkg::word_t  mem_rdata_i
);
    import mem_pkg::*;

    logic   ic_req, ic_done;
    word_t  ic_addr;
    logic   dc_req, dc_we, dc_done;
    word_t  dc_addr;
    line_t  dc_wline;
    logic   free;
    line_t  rline;     // shared by both caches

    icache_line u_icache (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .free_i        (free),
        .rline_i       (rline),
        .done_i        (ic_done),
        .req_o         (ic_req),
        .addr_o        (ic_addr)
    );

    dcache_line u_dcache (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_valid_o (data_valid_o),
        .data_rdata_o (data_rdata_o),
        .free_i       (free),
        .rline_i      (rline),
        .done_i       (dc_done),
        .req_o        (dc_req),
        .we_o         (dc_we),
        .addr_o       (dc_addr),
        .wline_o      (dc_wline)
    );

    line_mem_bridge u_bridge (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ic_req_i    (ic_req),
        .ic_addr_i   (ic_addr),
        .dc_req_i    (dc_req),
        .dc_we_i     (dc_we),
        .dc_addr_i   (dc_addr),
        .dc_wline_i  (dc_wline),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .free_o      (free),
        .rline_o     (rline),
        .ic_done_o   (ic_done),
        .dc_done_o   (dc_done),
        .mem_valid_o (mem_valid_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o)
    );

endmodule

// ==== mem_subsys_assert.sv ====
`timescale 1ns/1ps

module mem_subsys_assert (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  mem_pkg::bridge_state_t    state_i,
    input  logic                      mem_valid_i,
    input  logic                      mem_ready_i,
    input  mem_pkg::word_t            mem_addr_i,
    input  mem_pkg::word_t            mem_wdata_i,
    input  logic [3:0]                mem_wstrb_i,
    input  logic                      ic_done_i,
    input  logic                      dc_done_i
);
    import mem_pkg::*;

    // a stalled beat keeps everything on the port
    a_beat_held: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i)
            && $stable(mem_wdata_i) && $stable(mem_wstrb_i))
        else $error("memory beat changed while valid waited for ready");

    a_ic_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        ic_done_i |=> !ic_done_i)
        else $error("fetch done pulse longer than one cycle");

    a_dc_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        dc_done_i |=> !dc_done_i)
        else $error("data done pulse longer than one cycle");

    a_one_done: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(ic_done_i && dc_done_i))
        else $error("both done pulses high together");

    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_i == BR_IDLE) |-> !mem_valid_i)
        else $error("memory valid high while the bridge is idle");

endmodule

bind line_mem_bridge mem_subsys_assert u_bridge_assert (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .state_i     (state_r),
    .mem_valid_i (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o),
    .mem_wstrb_i (mem_wstrb_o),
    .ic_done_i   (ic_done_o),
    .dc_done_i   (dc_done_o)
);

// ==== mem_subsys_checker.sv ====
`timescale 1ns/1ps

module mem_subsys_checker (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            fetch_req_i,
    input  mem_pkg::word_t  fetch_addr_i,
    input  logic            fetch_valid_i,
    input  mem_pkg::word_t  fetch_data_i,
    input  int              fetch_tid_i,
    input  mem_pkg::word_t  fetch_exp_i,
    input  logic            fetch_hit_i,

    input  logic            data_req_i,
    input  logic            data_we_i,
    input  mem_pkg::word_t  data_addr_i,
    input  logic            data_valid_i,
    input  mem_pkg::word_t  data_rdata_i,
    input  int              data_tid_i,
    input  mem_pkg::word_t  data_exp_i,
    input  logic            data_hit_i,

    output int              pass_cnt_o,
    output int              fail_cnt_o
);
    import mem_pkg::*;

    int   n_pass = 0;
    int   n_fail = 0;
    int   f_lat;
    int   d_lat;
    logic f_busy;
    logic d_busy;

    task automatic finish_test(input string port, input int tid, input word_t addr,
                               input logic check_val, input string sig, input word_t exp,
                               input word_t got, input logic hit, input int lat);
        logic ok;
        ok = 1'b1;
        if (check_val && (got !== exp)) begin
            $display("error at %0t ns: %s expected %h got %h", $time, sig, exp, got);
            ok = 1'b0;
        end
        if (hit && (lat != 1)) begin
            $display("test %0d: %s answered %0d cycles after the request, a hit takes 1",
                     tid, port, lat);
            ok = 1'b0;
        end
        if (ok)
            n_pass++;
        else
            n_fail++;
        $display("test %0d %s %h: %s", tid, port, addr, ok ? "ok" : "failed");
    endtask

    always @(posedge clk_i) begin
        if (!rst_i) begin
            f_busy = 1'b0;
            d_busy = 1'b0;
            f_lat  = 0;
            d_lat  = 0;
        end else begin
            if (f_busy)
                f_lat++;
            if (fetch_valid_i) begin
                finish_test("fetch", fetch_tid_i, fetch_addr_i, 1'b1, "fetch_data_o",
                            fetch_exp_i, fetch_data_i, fetch_hit_i, f_lat);
                f_busy = 1'b0;
            end else if (fetch_req_i && !f_busy) begin
                f_busy = 1'b1;   // req first seen
                f_lat  = 0;
            end

            if (d_busy)
                d_lat++;
            if (data_valid_i) begin
                // stores return nothing to compare
                finish_test(data_we_i ? "store" : "load", data_tid_i, data_addr_i,
                            !data_we_i, "data_rdata_o", data_exp_i, data_rdata_i,
                            data_hit_i, d_lat);
                d_busy = 1'b0;
            end else if (data_req_i && !d_busy) begin
                d_busy = 1'b1;
                d_lat  = 0;
            end
        end
    end

    assign pass_cnt_o = n_pass;
    assign fail_cnt_o = n_fail;

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int MAX_OPS = 64;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        fetch_req_i;
    word_t       fetch_addr_i;
    logic        fetch_valid_o;
    word_t       fetch_data_o;
    logic        data_req_i;
    logic        data_we_i;
    word_t       data_addr_i;
    word_t       data_wdata_i;
    logic        data_valid_o;
    word_t       data_rdata_o;
    logic        mem_valid_o;
    word_t       mem_addr_o;
    word_t       mem_wdata_o;
    logic [3:0]  mem_wstrb_o;
    logic        mem_ready_i;
    word_t       mem_rdata_i;

    // expectations handed to the checker
    int          f_tid;
    word_t       f_exp;
    logic        f_hit;
    int          d_tid;
    word_t       d_exp;
    logic        d_hit;
    int          n_pass;
    int          n_fail;

    logic        g_is_data [MAX_OPS];
    logic        g_we      [MAX_OPS];
    logic        g_hit     [MAX_OPS];
    logic        g_pair    [MAX_OPS];
    word_t       g_addr    [MAX_OPS];
    word_t       g_wdata   [MAX_OPS];
    word_t       g_exp     [MAX_OPS];
    int          n_ops = 0;

    word_t       mem_q [word_t];         // only words written back
    logic [31:0] lcg_state = 32'd48579;
    int unsigned cycles = 0;
    int unsigned limit = 32'hFFFF_FFFF;
    int          idx;

    mem_subsys_top uut (.*);

    mem_subsys_checker u_checker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_i (fetch_valid_o),
        .fetch_data_i  (fetch_data_o),
        .fetch_tid_i   (f_tid),
        .fetch_exp_i   (f_exp),
        .fetch_hit_i   (f_hit),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .data_valid_i  (data_valid_o),
        .data_rdata_i  (data_rdata_o),
        .data_tid_i    (d_tid),
        .data_exp_i    (d_exp),
        .data_hit_i    (d_hit),
        .pass_cnt_o    (n_pass),
        .fail_cnt_o    (n_fail)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t mem_read(input word_t a);
        if (mem_q.exists(a))
            return mem_q[a];
        return a ^ 32'hA5A5_0000;
    endfunction

    // ready comes with the data for the held address, then drops for a cycle
    always @(posedge clk_i) begin
        lcg_state = lcg_next(lcg_state);
        if (mem_valid_o && mem_ready_i) begin
            if (mem_wstrb_o == 4'hF)
                mem_q[mem_addr_o] = mem_wdata_o;
            mem_ready_i <= 1'b0;
        end else if (mem_valid_o && lcg_state[16]) begin
            mem_ready_i <= 1'b1;
            mem_rdata_i <= mem_read(mem_addr_o);
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: a request never completed");
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic read_golden();
        int    fd;
        int    cnt;
        int    pr;
        string line_s;
        string port_s;
        string op_s;
        word_t a;
        word_t w;
        word_t e;
        fd = $fopen("mem_subsys_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open mem_subsys_golden.txt");
            return;
        end
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            cnt = $fgets(line_s, fd);
            if (cnt > 0 && line_s.len() > 1 && line_s[0] != "#") begin
                if ($sscanf(line_s, "%s %s %h %h %h %d", port_s, op_s, a, w, e, pr) == 6) begin
                    g_is_data[n_ops] = (port_s == "d");
                    g_we[n_ops]      = (op_s == "st");
                    g_hit[n_ops]     = (op_s == "ldh");
                    g_pair[n_ops]    = (pr != 0);
                    g_addr[n_ops]    = a;
                    g_wdata[n_ops]   = w;
                    g_exp[n_ops]     = e;
                    n_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    // fi or di below zero leaves that port idle
    task automatic run_test(input int fi, input int di);
        logic f_wait;
        logic d_wait;
        @(posedge clk_i);
        f_wait = (fi >= 0);
        d_wait = (di >= 0);
        if (f_wait) begin
            fetch_req_i  <= 1'b1;
            fetch_addr_i <= g_addr[fi];
            f_tid        <= fi + 1;
            f_exp        <= g_exp[fi];
            f_hit        <= g_hit[fi];
        end
        if (d_wait) begin
            data_req_i   <= 1'b1;
            data_we_i    <= g_we[di];
            data_addr_i  <= g_addr[di];
            data_wdata_i <= g_wdata[di];
            d_tid        <= di + 1;
            d_exp        <= g_exp[di];
            d_hit        <= g_hit[di];
        end
        while (f_wait || d_wait) begin
            @(posedge clk_i);
            if (f_wait && fetch_valid_o) begin
                fetch_req_i <= 1'b0;
                f_wait = 1'b0;
            end
            if (d_wait && data_valid_o) begin
                data_req_i <= 1'b0;
                d_wait = 1'b0;
            end
        end
    endtask

    initial begin
        rst_i        = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        mem_ready_i  = 1'b0;
        mem_rdata_i  = '0;
        f_tid        = 0;
        f_exp        = '0;
        f_hit        = 1'b0;
        d_tid        = 0;
        d_exp        = '0;
        d_hit        = 1'b0;

        read_golden();
        limit = n_ops * 60 + 200;   // two stalled bursts per operation
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b1;

        idx = 0;
        while (idx < n_ops) begin
            if (g_pair[idx] && (idx + 1 < n_ops)) begin
                if (g_is_data[idx])
                    run_test(idx + 1, idx);
                else
                    run_test(idx, idx + 1);
                idx += 2;
            end else begin
                if (g_is_data[idx])
                    run_test(-1, idx);
                else
                    run_test(idx, -1);
                idx++;
            end
        end

        repeat (2) @(posedge clk_i);
        $display("tests: %0d passed, %0d failed, %0d read", n_pass, n_fail, n_ops);
        if (n_ops > 0 && n_fail == 0 && n_pass == n_ops)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== mem_subsys_golden.txt ====
# port (f fetch, d data)  op (ld load, st store, ldh load that must hit)
# address  store-data  expected  pair (1 = issued together with the next line)
f ld  00000100 00000000 a5a50100 0
f ldh 00000100 00000000 a5a50100 0
f ldh 00000104 00000000 a5a50104 0
d ld  00000200 00000000 a5a50200 0
d st  00000204 deadbeef 00000000 0
d ldh 00000204 00000000 deadbeef 0
d ldh 00000208 00000000 a5a50208 0
d ld  00000280 00000000 a5a50280 0
d ld  00000204 00000000 deadbeef 0
d ldh 0000020c 00000000 a5a5020c 0
f ld  00000310 00000000 a5a50310 1
d ld  00000410 00000000 a5a50410 0
d st  00000414 12345678 00000000 0
f ld  00000390 00000000 a5a50390 1
d ld  00000494 00000000 a5a50494 0
d ld  00000414 00000000 12345678 0
f ldh 00000390 00000000 a5a50390 0
d st  00000520 cafef00d 00000000 0
d ldh 00000520 00000000 cafef00d 0
f ld  00000204 00000000 deadbeef 0

// ==== build.f ====
+incdir+.
mem_pkg.sv
line_mem_bridge.sv
icache_line.sv
dcache_line.sv
mem_subsys_top.sv
mem_subsys_assert.sv
mem_subsys_checker.sv
tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_mem_subsys -o sim_mem_subsys

out=$(./obj_dir/sim_mem_subsys 2>&1) || true
printf '%s\n' "$out"

if grep -qxF '*** PASSED ***' <<< "$out"; then
    exit 0
fi
exit 1
